// ==== list.f ====
design/backEndPkg.sv
design/executeUnit.sv
design/pipeStage.sv
design/pipeControl.sv
design/memoryStage.sv
design/backEnd.sv
verification/backEndTb.sv

// ==== Makefile ====
TOP = backEndTb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/backEndTb.sv ====
// Directed testbench for the back end, compiled from list.f and run by the Makefile.
module backEndTb;
   timeunit 1ns;
   timeprecision 1ps;
   import backEndPkg::*;

   localparam int resetCycles   = 8;
   localparam int testCount     = 6;
   localparam int cyclesPerTest = 60;
   localparam int watchdogNs    = (resetCycles + testCount * cyclesPerTest) * 10 + 500;

   logic                 clk = 1'b0;
   logic                 reset;
   execReq_t             issue;
   logic                 stall;
   memWb_t               retire;
   int                   seed = 32'h5a10;
   int                   edgeCount = 0;
   int                   errorCount = 0;
   int                   checkCount = 0;
   int                   lastErrors = 0;
   logic [dataWidth-1:0] tbMem [memDepth];
   memWb_t               expWb [$];
   int                   expDue [$];
   memWb_t               expEntry;
   int                   expEdge;

   backEnd backEnd_i (
      .clk    (clk),
      .reset  (reset),
      .issue  (issue),
      .stall  (stall),
      .retire (retire)
   );

   always #5 clk = ~clk;

   always @(posedge clk) edgeCount <= edgeCount + 1;

   initial begin
      #(watchdogNs);
      $display("watchdog expired after %0d ns, the run did not finish", watchdogNs);
      $display("TEST FAILED");
      $finish;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [dataWidth-1:0] randomWord();
      return dataWidth'($random(seed));
   endfunction

   function automatic logic [dataWidth-1:0] modelAlu(input aluOp_t op,
         input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
      logic [dataWidth-1:0] y;
      case (op)
         aluAdd:        y = a + b;
         aluSub:        y = a - b;
         aluAnd:        y = a & b;
         aluXor:        y = a ^ b;
         aluShiftLeft:  y = a * (16'd1 << b[3:0]);
         aluShiftRight: y = a / (16'd1 << b[3:0]);
         aluSetLess: begin
            // differing signs decide by the sign of A.
            if (a[dataWidth-1] != b[dataWidth-1]) y = dataWidth'(a[dataWidth-1]);
            else y = dataWidth'(a < b);
         end
         default:       y = b;
      endcase
      return y;
   endfunction

   function automatic execReq_t buildReq(input aluOp_t op, input logic [dataWidth-1:0] a,
         input logic [dataWidth-1:0] b, input wbSel_t sel, input logic [regAddrWidth-1:0] rd);
      execReq_t   r;
      logic [7:0] imm;
      imm         = 8'(randomWord());
      r           = '0;
      r.valid     = 1'b1;
      r.aluOp     = op;
      r.opA       = a;
      r.opB       = b;
      r.addPC     = randomWord();
      r.imm8      = {{8{imm[7]}}, imm};
      r.storeData = randomWord();
      r.wbSel     = sel;
      r.regWrt    = 1'b1;
      r.wrtReg    = rd;
      return r;
   endfunction

   task automatic checkValue(input string name, input logic [31:0] actual,
         input logic [31:0] expected);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
      end
   endtask

   // drive one request and wait until an edge with stall low takes it.
   task automatic sendReq(input execReq_t req, output int stallCycles);
      logic                    stalled;
      int                      takenEdge;
      logic [dataWidth-1:0]    aluY;
      logic [memAddrWidth-1:0] addr;
      memWb_t                  wb;
      stallCycles = 0;
      issue <= req;
      do begin
         @(negedge clk);
         stalled   = stall;
         takenEdge = edgeCount + 1;
         if (stalled) stallCycles++;
         @(posedge clk);
      end while (stalled);
      if (req.valid) begin
         aluY = modelAlu(req.aluOp, req.opA, req.opB);
         addr = aluY[memAddrWidth-1:0];
         if (req.regWrt) begin
            wb.regWrt = 1'b1;
            wb.wrtReg = req.wrtReg;
            case (req.wbSel)
               wbMem:   wb.wbData = tbMem[addr];
               wbLink:  wb.wbData = req.addPC;
               wbImm:   wb.wbData = req.imm8;
               default: wb.wbData = aluY;
            endcase
            expWb.push_back(wb);
            // loads and stores wait memWaitCycles extra edges.
            expDue.push_back(takenEdge + 1 +
               ((req.memWrt || req.readEn) ? memWaitCycles : 0));
         end
         if (req.memWrt) tbMem[addr] = req.storeData;
      end
   endtask

   task automatic drainRetire();
      int waited;
      int stalls;
      waited = 0;
      sendReq('0, stalls);
      while (expWb.size() != 0 && waited < 4 * memWaitCycles + 4) begin
         @(posedge clk);
         waited++;
      end
      if (expWb.size() != 0) begin
         errorCount++;
         $display("%0d expected register writes never reached retire", expWb.size());
         expWb.delete();
         expDue.delete();
      end
   endtask

   task automatic reportTest(input string name);
      $display("test %-12s finished with %0d errors", name, errorCount - lastErrors);
      lastErrors = errorCount;
   endtask

   // every register write at retire must match the oldest expected one.
   always @(negedge clk) begin
      if (!reset && retire.regWrt) begin
         if (expWb.size() == 0) begin
            errorCount++;
            $display("unexpected retirement to r%0d with 0x%h", retire.wrtReg, retire.wbData);
         end else begin
            expEntry = expWb.pop_front();
            expEdge  = expDue.pop_front();
            checkValue("retire.wrtReg", 32'(retire.wrtReg), 32'(expEntry.wrtReg));
            checkValue("retire.wbData", 32'(retire.wbData), 32'(expEntry.wbData));
            checkValue("retire edge", edgeCount, expEdge);
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // directed tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic testReset();
      repeat (6) begin
         @(negedge clk);
         checkValue("stall", 32'(stall), 32'd0);
         checkValue("retire.regWrt", 32'(retire.regWrt), 32'd0);
         @(posedge clk);
      end
      reportTest("reset");
   endtask

   task automatic testAluOps();
      int op;
      int stalls;
      for (op = 0; op < 8; op++) begin
         sendReq(buildReq(aluOp_t'(op), randomWord(), randomWord(), wbAlu,
            regAddrWidth'(op)), stalls);
         checkValue("alu stall cycles", stalls, 32'd0);
      end
      drainRetire();
      reportTest("aluOps");
   endtask

   task automatic testStoreLoad();
      execReq_t st;
      execReq_t ld;
      int       stalls;
      st        = buildReq(aluAdd, randomWord(), randomWord(), wbAlu, 3'd0);
      st.memWrt = 1'b1;
      st.regWrt = 1'b0;
      ld        = buildReq(aluAdd, st.opA, st.opB, wbMem, 3'd2);
      ld.readEn = 1'b1;
      sendReq(st, stalls);
      sendReq(ld, stalls);
      checkValue("store stall cycles", stalls, memWaitCycles);
      sendReq('0, stalls);
      checkValue("load stall cycles", stalls, memWaitCycles);
      drainRetire();
      reportTest("storeLoad");
   endtask

   task automatic testWbSources();
      int stalls;
      repeat (2) begin
         sendReq(buildReq(aluOp_t'(3'(randomWord())), randomWord(), randomWord(),
            wbLink, 3'd3), stalls);
         sendReq(buildReq(aluOp_t'(3'(randomWord())), randomWord(), randomWord(),
            wbImm, 3'd4), stalls);
      end
      drainRetire();
      reportTest("wbSources");
   endtask

   task automatic testBubbles();
      execReq_t st;
      execReq_t bubble;
      execReq_t ld;
      int       stalls;
      st               = buildReq(aluPassB, randomWord(), randomWord(), wbAlu, 3'd0);
      st.memWrt        = 1'b1;
      st.regWrt        = 1'b0;
      bubble           = st;
      bubble.valid     = 1'b0;
      bubble.regWrt    = 1'b1;
      bubble.wrtReg    = 3'd5;
      bubble.storeData = ~st.storeData;
      ld               = buildReq(aluPassB, randomWord(), st.opB, wbMem, 3'd6);
      ld.readEn        = 1'b1;
      sendReq(st, stalls);
      sendReq(bubble, stalls);
      sendReq(ld, stalls);
      checkValue("bubble stall cycles", stalls, 32'd0);
      drainRetire();
      reportTest("bubbles");
   endtask

   task automatic testBackPressure();
      execReq_t st;
      execReq_t ld;
      int       stalls;
      st        = buildReq(aluXor, randomWord(), randomWord(), wbAlu, 3'd0);
      st.memWrt = 1'b1;
      st.regWrt = 1'b0;
      ld        = buildReq(aluXor, st.opA, st.opB, wbMem, 3'd1);
      ld.readEn = 1'b1;
      sendReq(st, stalls);
      sendReq(ld, stalls);
      // held behind the load until its wait ends.
      sendReq(buildReq(aluSub, randomWord(), randomWord(), wbAlu, 3'd7), stalls);
      checkValue("held issue stall cycles", stalls, memWaitCycles);
      drainRetire();
      reportTest("backPressure");
   endtask

   initial begin
      reset = 1'b1;
      issue = '0;
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;
      testReset();
      testAluOps();
      testStoreLoad();
      testWbSources();
      testBubbles();
      testBackPressure();
      $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== design/backEnd.sv ====
// Top level of the processor back end from execute through the memory-to-writeback register.
module backEnd (
   input  logic                 clk,
   input  logic                 reset,
   input  backEndPkg::execReq_t issue,
   output logic                 stall,
   output backEndPkg::memWb_t   retire
);
   import backEndPkg::*;

   execMem_t executeOut;
   execMem_t memCurrent;
   memWb_t   memOut;
   logic     memFire;
   logic     x2mHold;
   logic     m2wFlush;

   executeUnit executeUnit_i (
      .issue  (issue),
      .result (executeOut)
   );

   // execute to memory.
   pipeStage #(
      .payload_t (execMem_t)
   ) x2mStage (
      .clk   (clk),
      .reset (reset),
      .hold  (x2mHold),
      .flush (1'b0),
      .d     (executeOut),
      .q     (memCurrent)
   );

   pipeControl pipeControl_i (
      .clk     (clk),
      .reset   (reset),
      .current (memCurrent),
      .memFire (memFire),
      .hold    (x2mHold),
      .flush   (m2wFlush),
      .stall   (stall)
   );

   memoryStage memoryStage_i (
      .clk     (clk),
      .current (memCurrent),
      .memFire (memFire),
      .result  (memOut)
   );

   // memory to writeback takes bubbles while stalled.
   pipeStage #(
      .payload_t (memWb_t)
   ) m2wStage (
      .clk   (clk),
      .reset (reset),
      .hold  (1'b0),
      .flush (m2wFlush),
      .d     (memOut),
      .q     (retire)
   );

endmodule

// ==== design/memoryStage.sv ====
// Memory stage holding the data array and selecting the writeback value.
module memoryStage (
   input  logic                 clk,
   input  backEndPkg::execMem_t current,
   input  logic                 memFire,
   output backEndPkg::memWb_t   result
);
   import backEndPkg::*;

   logic [dataWidth-1:0]    dataMem [memDepth];
   logic [memAddrWidth-1:0] memAddr;
   logic [dataWidth-1:0]    readWord;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // data array
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // word address from the low ALU bits.
   assign memAddr  = current.aluOut[memAddrWidth-1:0];
   assign readWord = dataMem[memAddr];

   always_ff @(posedge clk) begin
      if (memFire && current.memWrt) begin
         dataMem[memAddr] <= current.storeData;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // writeback select
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      result.regWrt = current.regWrt;
      result.wrtReg = current.wrtReg;
      result.wbData = current.aluOut;
      case (current.wbSel)
         wbAlu:  result.wbData = current.aluOut;
         wbMem:  result.wbData = readWord;
         wbLink: result.wbData = current.addPC;
         wbImm:  result.wbData = current.imm8;
      endcase
   end

   // the fire pulse from control only lands on a load or store.
   fireOnMemOp: assert property (
      @(posedge clk)
      memFire |-> (current.memWrt || current.readEn)
   ) else $error("memoryStage: memFire without a memory access");

endmodule

// ==== design/pipeControl.sv ====
// Memory wait control that stalls the front end and sequences the slow data memory.
module pipeControl (
   input  logic                 clk,
   input  logic                 reset,
   input  backEndPkg::execMem_t current,
   output logic                 memFire,
   output logic                 hold,
   output logic                 flush,
   output logic                 stall
);
   import backEndPkg::*;

   logic [waitCountWidth-1:0] waitCount;
   logic                      memOp;
   logic                      idle;
   logic                      fireCycle;

   assign memOp     = current.memWrt | current.readEn;
   assign idle      = waitCount == '0;
   assign fireCycle = waitCount == waitCountWidth'(memWaitCycles);

   // stall starts in the cycle the access arrives.
   assign stall   = (idle & memOp) | (!idle & !fireCycle);
   assign memFire = fireCycle;
   assign hold    = stall;
   assign flush   = stall;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // wait counter
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (reset) begin
         waitCount <= '0;
      end else if (fireCycle) begin
         waitCount <= '0;
      end else if (stall) begin
         waitCount <= waitCount + 1'b1;
      end
   end

   stallLength: assert property (
      @(posedge clk) disable iff (reset)
      $rose(stall) |-> stall [*memWaitCycles] ##1 !stall
   ) else $error("pipeControl: stall run has wrong length");

   // one fire per stall run.
   fireAfterStall: assert property (
      @(posedge clk) disable iff (reset)
      $fell(stall) |-> memFire ##1 !memFire
   ) else $error("pipeControl: memFire missing or repeated after stall");

endmodule

// ==== design/pipeStage.sv ====
// Pipeline stage register with hold and flush that the back end instantiates per payload type.
module pipeStage #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     hold,
   input  logic     flush,
   input  payload_t d,
   output payload_t q
);

   always_ff @(posedge clk) begin
      if (reset) begin
         q <= '0;
      end else if (flush) begin
         // all-zero payload is a bubble.
         q <= '0;
      end else if (!hold) begin
         q <= d;
      end
   end

   // control never asks one stage to both keep and drop its contents.
   holdFlushExclusive: assert property (
      @(posedge clk) disable iff (reset)
      !(hold && flush)
   ) else $error("pipeStage: hold and flush both high");

endmodule

// ==== design/executeUnit.sv ====
// Execute stage that turns an issued instruction into the execute-to-memory payload.
module executeUnit (
   input  backEndPkg::execReq_t issue,
   output backEndPkg::execMem_t result
);
   import backEndPkg::*;

   logic [dataWidth-1:0] aluResult;
   logic                 lessThan;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // ALU
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign lessThan = $signed(issue.opA) < $signed(issue.opB);

   always_comb begin
      aluResult = issue.opB;
      case (issue.aluOp)
         aluAdd:        aluResult = issue.opA + issue.opB;
         aluSub:        aluResult = issue.opA - issue.opB;
         aluAnd:        aluResult = issue.opA & issue.opB;
         aluXor:        aluResult = issue.opA ^ issue.opB;
         // shift amount is the low nibble of B.
         aluShiftLeft:  aluResult = issue.opA << issue.opB[3:0];
         aluShiftRight: aluResult = issue.opA >> issue.opB[3:0];
         aluSetLess:    aluResult = dataWidth'(lessThan);
         aluPassB:      aluResult = issue.opB;
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // payload
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      result.aluOut    = aluResult;
      result.addPC     = issue.addPC;
      result.imm8      = issue.imm8;
      result.storeData = issue.storeData;
      result.wbSel     = issue.wbSel;
      result.wrtReg    = issue.wrtReg;
      // a bubble must not touch memory or the register file.
      result.memWrt    = issue.valid & issue.memWrt;
      result.readEn    = issue.valid & issue.readEn;
      result.regWrt    = issue.valid & issue.regWrt;
   end

   // a request is a load or a store, never both.
   always_comb begin
      if (issue.valid) begin
         loadStoreExclusive: assert (!(issue.memWrt && issue.readEn))
            else $error("executeUnit: memWrt and readEn both set");
      end
   end

endmodule

// ==== design/backEndPkg.sv ====
// Shared widths, enumerations and payload structs used by every back-end module.
package backEndPkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // sizes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int unsigned dataWidth      = 16;
   localparam int unsigned regAddrWidth   = 3;
   localparam int unsigned memDepth       = 256;
   localparam int unsigned memAddrWidth   = $clog2(memDepth);
   localparam int unsigned memWaitCycles  = 2;
   localparam int unsigned waitCountWidth = $clog2(memWaitCycles + 1);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // encodings
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [2:0] {
      aluAdd        = 3'd0,
      aluSub        = 3'd1,
      aluAnd        = 3'd2,
      aluXor        = 3'd3,
      aluShiftLeft  = 3'd4,
      aluShiftRight = 3'd5,
      aluSetLess    = 3'd6,
      aluPassB      = 3'd7
   } aluOp_t;

   // writeback source.
   typedef enum logic [1:0] {
      wbAlu  = 2'd0,
      wbMem  = 2'd1,
      wbLink = 2'd2,
      wbImm  = 2'd3
   } wbSel_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // payloads
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // decoded instruction from the front end.
   typedef struct packed {
      logic                    valid;
      aluOp_t                  aluOp;
      logic [dataWidth-1:0]    opA;
      logic [dataWidth-1:0]    opB;
      logic [dataWidth-1:0]    addPC;
      logic [dataWidth-1:0]    imm8;
      logic [dataWidth-1:0]    storeData;
      logic                    memWrt;
      logic                    readEn;
      wbSel_t                  wbSel;
      logic                    regWrt;
      logic [regAddrWidth-1:0] wrtReg;
   } execReq_t;

   // execute to memory.
   typedef struct packed {
      logic [dataWidth-1:0]    aluOut;
      logic [dataWidth-1:0]    addPC;
      logic [dataWidth-1:0]    imm8;
      logic [dataWidth-1:0]    storeData;
      logic                    memWrt;
      logic                    readEn;
      wbSel_t                  wbSel;
      logic                    regWrt;
      logic [regAddrWidth-1:0] wrtReg;
   } execMem_t;

   // memory to writeback.
   typedef struct packed {
      logic                    regWrt;
      logic [regAddrWidth-1:0] wrtReg;
      logic [dataWidth-1:0]    wbData;
   } memWb_t;

endpackage
